// File: source/az_cfg.svh
////////////////////
// switch levels, mux codes, widths and register addresses of the auto-zero block
// included by the package and by every module that needs a width or a code
////////////////////

`ifndef AZ_CFG_SVH
`define AZ_CFG_SVH

// precharge switch, boot protects the signal, signal passes it to the az mux
`define AZ_SW_PC_BOOT      1'b0
`define AZ_SW_PC_SIGNAL    1'b1

// az mux code that selects the precharge output (the hi side)
`define AZ_AZMUX_PCOUT     4'b0001

// widths
`define AZ_MUX_W           4
`define AZ_ADC_W           24
`define AZ_CNT_W           24

// wishbone word addresses, 3 bit
`define AZ_REG_CTRL        3'd0
`define AZ_REG_PRECHARGE   3'd1
`define AZ_REG_LOMUX       3'd2
`define AZ_REG_STATUS      3'd3
`define AZ_REG_RESULT      3'd4
`define AZ_REG_HI          3'd5
`define AZ_REG_LO          3'd6
`define AZ_REG_COUNT       3'd7

`endif

// File: source/az_pkg.sv
////////////////////
// shared types of the auto-zero block, referenced by scoped name
////////////////////

`default_nettype none

`include "az_cfg.svh"

package az_pkg;

  // one raw adc reading, two's complement
  typedef logic signed [`AZ_ADC_W-1:0] adc_sample_t;

  // hi minus lo needs one extra bit so it never wraps
  typedef logic signed [`AZ_ADC_W:0] az_result_t;

  ////////////////////
  // sequencer phases
  // reported in status bits 7:4, so keep the encoding stable
  typedef enum logic [3:0] {
    PARK      = 4'd0,
    START     = 4'd1,
    PC_BOOT   = 4'd2,
    PC_SETTLE = 4'd3,
    HI_SETTLE = 4'd4,
    HI_WAIT   = 4'd5,
    LO_BOOT   = 4'd6,
    LO_SETTLE = 4'd7,
    LO_WAIT   = 4'd8
  } az_phase_t;

endpackage

`default_nettype wire

// File: source/az_wb_regs.sv
////////////////////
// wishbone classic register slave, holds the controls and reads back status and results
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "az_cfg.svh"

module az_wb_regs
(
  input  wire                       clk,
  input  wire                       rst_n,

  // wishbone classic slave
  input  wire                       wb_cyc,
  input  wire                       wb_stb,
  input  wire                       wb_we,
  input  wire [2:0]                 wb_adr,
  input  wire [31:0]                wb_dat_w,
  output logic [31:0]               wb_dat_r,
  output logic                      wb_ack,

  // status and results coming back
  input  wire az_pkg::az_phase_t    phase,
  input  wire                       hilo_status,
  input  wire                       ready,
  input  wire                       overrun,
  input  wire az_pkg::az_result_t   corrected,
  input  wire az_pkg::adc_sample_t  hi,
  input  wire az_pkg::adc_sample_t  lo,
  input  wire [`AZ_CNT_W-1:0]       count,

  // controls to the sequencer
  output logic                      arm,
  output logic [`AZ_CNT_W-1:0]      precharge_count,
  output logic [`AZ_MUX_W-1:0]      lo_mux,
  output logic                      result_read
);

  // precharge count out of reset, a few clocks only
  localparam logic [`AZ_CNT_W-1:0] PRECHARGE_RST = 4;

  logic        wb_req;
  logic [31:0] rd_data;

  // new cycle seen, ack not yet given
  assign wb_req = wb_cyc & wb_stb & ~wb_ack;

  ////////////////////
  // read mux
  always_comb
  begin
    rd_data = '0;
    case (wb_adr)
      `AZ_REG_CTRL:
        rd_data = {31'b0, arm};
      `AZ_REG_PRECHARGE:
        rd_data = {{(32-`AZ_CNT_W){1'b0}}, precharge_count};
      `AZ_REG_LOMUX:
        rd_data = {{(32-`AZ_MUX_W){1'b0}}, lo_mux};
      // bit 3 reserved, reads zero
      `AZ_REG_STATUS:
        rd_data = {24'b0, phase, 1'b0, hilo_status, overrun, ready};
      // corrected value sign-extended to the bus
      `AZ_REG_RESULT:
        rd_data = {{(31-`AZ_ADC_W){corrected[`AZ_ADC_W]}}, corrected};
      `AZ_REG_HI:
        rd_data = {{(32-`AZ_ADC_W){hi[`AZ_ADC_W-1]}}, hi};
      `AZ_REG_LO:
        rd_data = {{(32-`AZ_ADC_W){lo[`AZ_ADC_W-1]}}, lo};
      `AZ_REG_COUNT:
        rd_data = {{(32-`AZ_CNT_W){1'b0}}, count};
      default:
        rd_data = '0;
    endcase
  end

  ////////////////////
  // ack, strobe and control registers
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ack          <= 1'b0;
      result_read     <= 1'b0;
      arm             <= 1'b0;
      precharge_count <= PRECHARGE_RST;
      lo_mux          <= '0;
    end
    else
    begin
      // single cycle ack, a held request never gets two
      wb_ack      <= wb_req;
      // reading RESULT hands the pair to the host
      result_read <= wb_req & ~wb_we & (wb_adr == `AZ_REG_RESULT);

      // write lands on the same edge that raises ack
      if (wb_req && wb_we)
      begin
        case (wb_adr)
          `AZ_REG_CTRL:      arm             <= wb_dat_w[0];
          `AZ_REG_PRECHARGE: precharge_count <= wb_dat_w[`AZ_CNT_W-1:0];
          `AZ_REG_LOMUX:     lo_mux          <= wb_dat_w[`AZ_MUX_W-1:0];
          // status and results ignore writes
          default:           ;
        endcase
      end
    end
  end

  // read data, only looked at while ack is high
  always_ff @(posedge clk)
  begin
    if (wb_req)
      wb_dat_r <= rd_data;
  end

endmodule

`default_nettype wire

// File: source/az_sequencer.sv
////////////////////
// auto-zero sequencer, steps precharge switch and az mux and triggers the adc
// every timed phase lasts precharge_count + 1 clocks
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "az_cfg.svh"

module az_sequencer
(
  input  wire                     clk,
  input  wire                     rst_n,

  // level controls from the registers
  input  wire                     arm,
  input  wire [`AZ_CNT_W-1:0]     precharge_count,
  input  wire [`AZ_MUX_W-1:0]     lo_mux,

  // adc handshake
  input  wire                     adc_valid,
  output logic                    adc_trig,

  // to the result block
  output logic                    sample_take,
  output logic                    sample_hi,

  // analog switch controls
  output logic                    sw_pc,
  output logic [`AZ_MUX_W-1:0]    azmux,
  output logic                    led,

  output az_pkg::az_phase_t       phase,
  output logic [1:0]              monitor
);

  // phase timer, loaded on entry to every timed phase
  logic [`AZ_CNT_W-1:0] cnt;

  // registered arm plus its previous value, {old, new}
  logic [1:0]           arm_hist;

  logic                 waiting;

  // a valid counts only in a wait phase and after our own trigger cycle
  assign waiting     = (phase == az_pkg::HI_WAIT) || (phase == az_pkg::LO_WAIT);
  assign sample_take = waiting & ~adc_trig & adc_valid;
  assign sample_hi   = (phase == az_pkg::HI_WAIT);

  // scope pins
  assign monitor[0] = adc_trig;
  // high while the hi side is on the mux
  assign monitor[1] = (azmux == `AZ_AZMUX_PCOUT);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase    <= az_pkg::PARK;
      cnt      <= '0;
      arm_hist <= 2'b00;
      adc_trig <= 1'b0;
      sw_pc    <= `AZ_SW_PC_BOOT;
      azmux    <= '0;
      led      <= 1'b0;
    end
    else
    begin
      arm_hist <= {arm_hist[0], arm};

      case (phase)
        // idle, switches left where parking put them
        az_pkg::PARK:
          ;

        // one clock, then protect the signal with the precharge switch
        az_pkg::START:
        begin
          adc_trig <= 1'b0;
          sw_pc    <= `AZ_SW_PC_BOOT;
          cnt      <= precharge_count;
          phase    <= az_pkg::PC_BOOT;
        end

        ////////////////////
        // hi half
        az_pkg::PC_BOOT:
          if (cnt == '0)
          begin
            // az mux to the precharge output, signal still shielded
            azmux <= `AZ_AZMUX_PCOUT;
            led   <= 1'b1;
            cnt   <= precharge_count;
            phase <= az_pkg::PC_SETTLE;
          end
          else
            cnt <= cnt - 1'b1;

        az_pkg::PC_SETTLE:
          if (cnt == '0)
          begin
            // pc switch onto the signal, let sig/boot offset settle
            sw_pc <= `AZ_SW_PC_SIGNAL;
            cnt   <= precharge_count;
            phase <= az_pkg::HI_SETTLE;
          end
          else
            cnt <= cnt - 1'b1;

        az_pkg::HI_SETTLE:
          if (cnt == '0)
          begin
            // start the hi conversion
            adc_trig <= 1'b1;
            phase    <= az_pkg::HI_WAIT;
          end
          else
            cnt <= cnt - 1'b1;

        az_pkg::HI_WAIT:
        begin
          adc_trig <= 1'b0;
          if (sample_take)
          begin
            // back to boot before the mux leaves the signal
            sw_pc <= `AZ_SW_PC_BOOT;
            led   <= 1'b0;
            cnt   <= precharge_count;
            phase <= az_pkg::LO_BOOT;
          end
        end

        ////////////////////
        // lo half
        az_pkg::LO_BOOT:
          if (cnt == '0)
          begin
            azmux <= lo_mux;
            cnt   <= precharge_count;
            phase <= az_pkg::LO_SETTLE;
          end
          else
            cnt <= cnt - 1'b1;

        az_pkg::LO_SETTLE:
          if (cnt == '0)
          begin
            // start the lo conversion
            adc_trig <= 1'b1;
            phase    <= az_pkg::LO_WAIT;
          end
          else
            cnt <= cnt - 1'b1;

        az_pkg::LO_WAIT:
        begin
          adc_trig <= 1'b0;
          if (sample_take)
          begin
            // pc switch already at boot, go straight to the mux move
            azmux <= `AZ_AZMUX_PCOUT;
            led   <= 1'b1;
            cnt   <= precharge_count;
            phase <= az_pkg::PC_SETTLE;
          end
        end

        default:
          phase <= az_pkg::PARK;
      endcase

      // arm edges win over whatever the phase logic chose
      if (arm_hist == 2'b01)
        phase <= az_pkg::START;
      else if (arm_hist == 2'b10)
      begin
        // park with the signal shielded and no conversion outstanding
        phase    <= az_pkg::PARK;
        adc_trig <= 1'b0;
        sw_pc    <= `AZ_SW_PC_BOOT;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/az_result.sv
////////////////////
// pairs hi and lo readings into the corrected value and counts the pairs
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "az_cfg.svh"

module az_result
(
  input  wire                       clk,
  input  wire                       rst_n,

  // take strobe and side from the sequencer
  input  wire                       sample_take,
  input  wire                       sample_hi,
  input  wire az_pkg::adc_sample_t  adc_data,

  // host has read RESULT
  input  wire                       result_read,

  output az_pkg::adc_sample_t       hi,
  output az_pkg::adc_sample_t       lo,
  output az_pkg::az_result_t        corrected,
  output logic [`AZ_CNT_W-1:0]      count,
  output logic                      ready,
  output logic                      overrun,
  output logic                      hilo_status
);

  logic take_hi;
  logic take_lo;

  assign take_hi = sample_take & sample_hi;
  // a lo take completes a pair
  assign take_lo = sample_take & ~sample_hi;

  ////////////////////
  // readings and difference
  always_ff @(posedge clk)
  begin
    if (take_hi)
      hi <= adc_data;
    if (take_lo)
    begin
      lo <= adc_data;
      // sign-extend both by one bit before subtracting
      corrected <= {hi[`AZ_ADC_W-1], hi} - {adc_data[`AZ_ADC_W-1], adc_data};
    end
  end

  ////////////////////
  // flags and pair count
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count       <= '0;
      ready       <= 1'b0;
      overrun     <= 1'b0;
      hilo_status <= 1'b0;
    end
    else
    begin
      if (take_hi)
        hilo_status <= 1'b1;

      if (take_lo)
      begin
        hilo_status <= 1'b0;
        // wraps at full scale
        count       <= count + 1'b1;
        ready       <= 1'b1;
      end
      else if (result_read)
        ready <= 1'b0;

      // previous pair never read, unless it is being read right now
      if (result_read)
        overrun <= 1'b0;
      else if (take_lo && ready)
        overrun <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/az_acquisition_top.sv
////////////////////
// auto-zero acquisition top, wishbone registers, sequencer and result block
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "az_cfg.svh"

module az_acquisition_top
(
  input  wire                       clk,
  input  wire                       rst_n,

  // wishbone classic slave
  input  wire                       wb_cyc,
  input  wire                       wb_stb,
  input  wire                       wb_we,
  input  wire [2:0]                 wb_adr,
  input  wire [31:0]                wb_dat_w,
  output wire [31:0]                wb_dat_r,
  output wire                       wb_ack,

  // adc port
  output wire                       adc_trig,
  input  wire                       adc_valid,
  input  wire az_pkg::adc_sample_t  adc_data,

  // switches and indicators
  output wire                       sw_pc,
  output wire [`AZ_MUX_W-1:0]       azmux,
  output wire                       led,
  output wire [1:0]                 monitor
);

  // registers to sequencer
  logic                     arm;
  logic [`AZ_CNT_W-1:0]     precharge_count;
  logic [`AZ_MUX_W-1:0]     lo_mux;

  // sequencer to result block
  logic                     sample_take;
  logic                     sample_hi;
  az_pkg::az_phase_t        phase;

  // result block to registers
  az_pkg::adc_sample_t      hi;
  az_pkg::adc_sample_t      lo;
  az_pkg::az_result_t       corrected;
  logic [`AZ_CNT_W-1:0]     count;
  logic                     ready;
  logic                     overrun;
  logic                     hilo_status;
  logic                     result_read;

  az_wb_regs az_wb_regs_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .wb_dat_r        (wb_dat_r),
    .wb_ack          (wb_ack),
    .phase           (phase),
    .hilo_status     (hilo_status),
    .ready           (ready),
    .overrun         (overrun),
    .corrected       (corrected),
    .hi              (hi),
    .lo              (lo),
    .count           (count),
    .arm             (arm),
    .precharge_count (precharge_count),
    .lo_mux          (lo_mux),
    .result_read     (result_read)
  );

  az_sequencer az_sequencer_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .arm             (arm),
    .precharge_count (precharge_count),
    .lo_mux          (lo_mux),
    .adc_valid       (adc_valid),
    .adc_trig        (adc_trig),
    .sample_take     (sample_take),
    .sample_hi       (sample_hi),
    .sw_pc           (sw_pc),
    .azmux           (azmux),
    .led             (led),
    .phase           (phase),
    .monitor         (monitor)
  );

  az_result az_result_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .sample_take     (sample_take),
    .sample_hi       (sample_hi),
    .adc_data        (adc_data),
    .result_read     (result_read),
    .hi              (hi),
    .lo              (lo),
    .corrected       (corrected),
    .count           (count),
    .ready           (ready),
    .overrun         (overrun),
    .hilo_status     (hilo_status)
  );

endmodule

`default_nettype wire

// File: bench/az_tb.sv
////////////////////
// testbench of the auto-zero block, wishbone host, adc model and assertions
// runs six checks in order, one line per check and a summary at the end
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "az_cfg.svh"

module az_tb;

  // every handshake and poll gives up after this many tries
  localparam int TIMEOUT = 2000;

  logic                 clk;
  logic                 rst_n;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [2:0]           wb_adr;
  logic [31:0]          wb_dat_w;
  logic [31:0]          wb_dat_r;
  logic                 wb_ack;
  logic                 adc_trig;
  logic                 adc_valid;
  az_pkg::adc_sample_t  adc_data;
  logic                 sw_pc;
  logic [`AZ_MUX_W-1:0] azmux;
  logic                 led;
  logic [1:0]           monitor;

  // error and test bookkeeping
  int                   errors;
  int                   mark;
  int                   tests_passed;
  int                   tests_failed;
  integer               seed;

  // adc model state, pairs stored by pair number
  int                   lo_trigs;
  int                   delay;
  logic                 conv_hi;
  logic                 next_hi;
  logic [31:0]          raw;
  az_pkg::adc_sample_t  cur_hi;
  az_pkg::adc_sample_t  hi_q[$];
  az_pkg::adc_sample_t  lo_q[$];

  // switches for the concurrent checks
  logic                 gap_check_on;
  logic                 park_check_on;
  logic [`AZ_MUX_W-1:0] exp_lo_mux;

  az_acquisition_top az_acquisition_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .adc_trig  (adc_trig),
    .adc_valid (adc_valid),
    .adc_data  (adc_data),
    .sw_pc     (sw_pc),
    .azmux     (azmux),
    .led       (led),
    .monitor   (monitor)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  ////////////////////
  // adc model
  // answers each trigger 3 to 20 clocks later
  // conversions alternate hi then lo, starting with hi after every arm
  always @(negedge clk)
  begin
    if (rst_n && adc_trig)
    begin
      conv_hi = next_hi;
      next_hi = ~next_hi;
      if (!conv_hi)
        lo_trigs++;
      raw   = $random(seed);
      delay = 3 + int'(raw[15:0]) % 18;
      repeat (delay) @(negedge clk);
      raw       = $random(seed);
      adc_data  = raw[`AZ_ADC_W-1:0];
      adc_valid = 1'b1;
      if (conv_hi)
        cur_hi = adc_data;
      else
      begin
        // a lo reading closes a pair
        hi_q.push_back(cur_hi);
        lo_q.push_back(adc_data);
      end
      @(negedge clk);
      adc_valid = 1'b0;
    end
  end

  ////////////////////
  // concurrent checks

  // precharge switch never drops to boot in a trigger cycle
  sw_fall_vs_trig: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(sw_pc) |-> !adc_trig)
  else
  begin
    errors++;
    $display("Error: adc_trig is %h while sw_pc falls", $sampled(adc_trig));
  end

  // az mux never moves in a trigger cycle
  mux_move_vs_trig: assert property (@(posedge clk) disable iff (!rst_n)
    (azmux != $past(azmux)) |-> !adc_trig)
  else
  begin
    errors++;
    $display("Error: adc_trig is %h while azmux moves to %h",
             $sampled(adc_trig), $sampled(azmux));
  end

  hi_trig_on_signal: assert property (@(posedge clk) disable iff (!rst_n)
    (adc_trig && conv_hi) |-> (sw_pc == `AZ_SW_PC_SIGNAL))
  else
  begin
    errors++;
    $display("Error: sw_pc is %h at a hi trigger, expected %h",
             $sampled(sw_pc), `AZ_SW_PC_SIGNAL);
  end

  // led marks the hi half
  led_half: assert property (@(posedge clk) disable iff (!rst_n)
    adc_trig |-> (led == conv_hi))
  else
  begin
    errors++;
    $display("Error: led is %h at a trigger, expected %h",
             $sampled(led), $sampled(conv_hi));
  end

  // scope pins, trigger copy and precharge select
  monitor_pins: assert property (@(posedge clk) disable iff (!rst_n)
    monitor == {azmux == `AZ_AZMUX_PCOUT, adc_trig})
  else
  begin
    errors++;
    $display("Error: monitor is %h, expected %h", $sampled(monitor),
             {$sampled(azmux) == `AZ_AZMUX_PCOUT, $sampled(adc_trig)});
  end

  // with precharge 6 the mux leads the switch by 7 clocks
  settle_gap: assert property (@(posedge clk) disable iff (!rst_n || !gap_check_on)
    $rose(sw_pc) |-> ($past(azmux, 7) == `AZ_AZMUX_PCOUT && $past(azmux, 8) != `AZ_AZMUX_PCOUT))
  else
  begin
    errors++;
    $display("sw_pc did not turn to signal exactly 7 clocks after azmux turned to PCOUT");
  end

  hi_trig_mux: assert property (@(posedge clk) disable iff (!rst_n)
    (adc_trig && conv_hi) |-> (azmux == `AZ_AZMUX_PCOUT))
  else
  begin
    errors++;
    $display("Error: azmux is %h at a hi trigger, expected %h",
             $sampled(azmux), `AZ_AZMUX_PCOUT);
  end

  lo_trig_mux: assert property (@(posedge clk) disable iff (!rst_n)
    (adc_trig && !conv_hi) |-> (azmux == exp_lo_mux))
  else
  begin
    errors++;
    $display("Error: azmux is %h at a lo trigger, expected %h",
             $sampled(azmux), $sampled(exp_lo_mux));
  end

  // parked means quiet and shielded
  park_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    park_check_on |-> (!adc_trig && sw_pc == `AZ_SW_PC_BOOT))
  else
  begin
    errors++;
    $display("Error: adc_trig %h sw_pc %h while parked", $sampled(adc_trig), $sampled(sw_pc));
  end

  ////////////////////
  // helpers

  task automatic abort_on_timeout(input string what);
    $display("timeout, %s never happened", what);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic close_test(input string name);
    if (errors == mark)
    begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: %0d error(s)", name, errors - mark);
    end
    mark = errors;
  endtask

  // one classic cycle, started and ended on a falling edge
  task automatic wb_transfer(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
    int n;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    n        = 0;
    do
    begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
        abort_on_timeout("wishbone ack");
    end
    while (!wb_ack);
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_transfer(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
    wb_transfer(1'b0, adr, 32'h0, data);
  endtask

  // read a register until the masked bits match, hands back the matching word
  task automatic poll_reg(input logic [2:0] adr, input logic [31:0] mask,
                          input logic [31:0] value, input string what,
                          output logic [31:0] data);
    int n;
    n = 0;
    wb_read(adr, data);
    while ((data & mask) != value)
    begin
      n++;
      if (n > TIMEOUT)
        abort_on_timeout(what);
      wb_read(adr, data);
    end
  endtask

  task automatic wait_phase(input az_pkg::az_phase_t p, input string what);
    logic [31:0] d;
    poll_reg(`AZ_REG_STATUS, 32'h0000_00f0, {24'b0, p, 4'b0}, what, d);
  endtask

  task automatic wait_lo_trigs(input int n);
    int target;
    int waited;
    target = lo_trigs + n;
    waited = 0;
    while (lo_trigs < target)
    begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT)
        abort_on_timeout("lo adc trigger");
    end
  endtask

  // compare one finished pair with the adc model, RESULT read last
  task automatic check_pair(input logic [31:0] base);
    logic [31:0] rd_hi;
    logic [31:0] rd_lo;
    logic [31:0] rd_cnt;
    logic [31:0] rd_res;
    int          idx;
    int          diff;
    wb_read(`AZ_REG_HI, rd_hi);
    wb_read(`AZ_REG_LO, rd_lo);
    wb_read(`AZ_REG_COUNT, rd_cnt);
    wb_read(`AZ_REG_RESULT, rd_res);
    check_value("COUNT", rd_cnt, base + 1);
    idx = int'(rd_cnt) - 1;
    if (idx < 0 || idx >= hi_q.size())
    begin
      errors++;
      $display("the adc model has no reading pair for pair count %0d", rd_cnt);
    end
    else
    begin
      diff = int'(hi_q[idx]) - int'(lo_q[idx]);
      check_value("HI", rd_hi, int'(hi_q[idx]));
      check_value("LO", rd_lo, int'(lo_q[idx]));
      check_value("RESULT", rd_res, diff);
    end
  endtask

  ////////////////////
  // main sequence
  initial
  begin
    logic [31:0] rd;
    logic [31:0] prev;
    clk           = 1'b0;
    rst_n         = 1'b0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    adc_valid     = 1'b0;
    adc_data      = '0;
    seed          = 47;
    errors        = 0;
    mark          = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    lo_trigs      = 0;
    conv_hi       = 1'b0;
    next_hi       = 1'b1;
    cur_hi        = '0;
    gap_check_on  = 1'b0;
    park_check_on = 1'b0;
    exp_lo_mux    = '0;

    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // outputs and registers straight out of reset
    check_value("adc_trig", adc_trig, 1'b0);
    check_value("led", led, 1'b0);
    check_value("azmux", azmux, '0);
    check_value("sw_pc", sw_pc, `AZ_SW_PC_BOOT);
    wb_read(`AZ_REG_PRECHARGE, rd);
    check_value("PRECHARGE", rd, 32'd4);
    wb_read(`AZ_REG_LOMUX, rd);
    check_value("LOMUX", rd, 32'd0);
    wb_read(`AZ_REG_STATUS, rd);
    check_value("STATUS phase and ready", rd & 32'h0000_00f1, 32'h0);
    close_test("reset state");

    // arm with precharge 6, ordering checked by the properties
    wb_write(`AZ_REG_PRECHARGE, 32'd6);
    wb_read(`AZ_REG_PRECHARGE, rd);
    check_value("PRECHARGE", rd, 32'd6);
    gap_check_on = 1'b1;
    wb_write(`AZ_REG_CTRL, 32'd1);
    wait_lo_trigs(3);
    close_test("switch ordering");

    // start in the hi half, well away from a lo take
    wait_phase(az_pkg::HI_WAIT, "hi wait phase");
    wb_read(`AZ_REG_RESULT, rd);
    wb_read(`AZ_REG_COUNT, prev);
    repeat (4)
    begin
      poll_reg(`AZ_REG_STATUS, 32'h1, 32'h1, "ready", rd);
      // just after a lo take
      check_value("STATUS hi/lo", rd[2], 1'b0);
      check_pair(prev);
      prev = prev + 1;
    end
    // hi reading taken, lo pending
    poll_reg(`AZ_REG_STATUS, 32'h0000_00f0, {24'b0, az_pkg::LO_WAIT, 4'b0},
             "lo wait phase", rd);
    check_value("STATUS hi/lo", rd[2], 1'b1);
    close_test("corrected result");

    // lo mux is latched in LO_BOOT, so change it during HI_WAIT
    wait_phase(az_pkg::HI_WAIT, "hi wait phase");
    exp_lo_mux = 4'd5;
    wb_write(`AZ_REG_LOMUX, 32'd5);
    wait_lo_trigs(2);
    wait_phase(az_pkg::HI_WAIT, "hi wait phase");
    exp_lo_mux = 4'd9;
    wb_write(`AZ_REG_LOMUX, 32'd9);
    wait_lo_trigs(2);
    wb_read(`AZ_REG_LOMUX, rd);
    check_value("LOMUX", rd, 32'd9);
    close_test("lo mux");

    // let two pairs pile up unread
    wait_phase(az_pkg::HI_WAIT, "hi wait phase");
    wb_read(`AZ_REG_RESULT, rd);
    wb_read(`AZ_REG_COUNT, prev);
    poll_reg(`AZ_REG_COUNT, 32'hffff_ffff, prev + 2, "second unread pair", rd);
    wb_read(`AZ_REG_STATUS, rd);
    check_value("STATUS overrun", rd[1], 1'b1);
    check_value("STATUS ready", rd[0], 1'b1);
    wb_read(`AZ_REG_RESULT, rd);
    wb_read(`AZ_REG_STATUS, rd);
    check_value("STATUS ready and overrun", rd[1:0], 2'b00);
    close_test("overrun");

    // park, stay quiet for 200 clocks, then resume
    gap_check_on = 1'b0;
    wb_write(`AZ_REG_CTRL, 32'd0);
    wait_phase(az_pkg::PARK, "park phase");
    park_check_on = 1'b1;
    wb_read(`AZ_REG_COUNT, prev);
    repeat (200) @(negedge clk);
    wb_read(`AZ_REG_COUNT, rd);
    check_value("COUNT", rd, prev);
    park_check_on = 1'b0;
    // a fresh arm restarts with the hi half
    next_hi = 1'b1;
    wb_write(`AZ_REG_CTRL, 32'd1);
    wait_lo_trigs(1);
    close_test("park");

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+source
source/az_pkg.sv
source/az_wb_regs.sv
source/az_sequencer.sv
source/az_result.sv
source/az_acquisition_top.sv
bench/az_tb.sv

// File: run.sh
#!/bin/sh
# compile the auto-zero testbench with verilator, run it, then look for the pass line
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f all.f \
  --top-module az_tb \
  -o az_sim

./obj_dir/az_sim | tee sim.log

if grep -qx "TEST PASSED" sim.log
then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
